// ==== logic/heapPkg.sv ====
//------------------------------------------------
// Heap definitions shared by both stages
// Sizes, opcodes, error codes and the request,
// checked request and result words
//------------------------------------------------
package heapPkg;

  // Sizes -------------------------------------------
  localparam int addressBits = 2;                      // Bits in an array handle
  localparam int indexBits   = 3;                      // Bits in an element index
  localparam int dataBits    = 16;                     // Element width
  localparam int arrayCount  = 2 ** addressBits;       // Number of arrays
  localparam int arrayLength = 2 ** indexBits;         // Elements per array

  // Opcodes and error codes -------------------------
  typedef enum logic [4:0] {
    idle     = 5'd0,                                   // No command this cycle
    clearAll = 5'd1,                                   // Forget every array
    alloc    = 5'd2,                                   // Grant a handle
    free     = 5'd3,                                   // Return a handle
    write    = 5'd4,                                   // Store an element
    read     = 5'd5,                                   // Fetch an element
    size     = 5'd6,                                   // Current array size
    push     = 5'd7,                                   // Append at the end
    pop      = 5'd8,                                   // Remove from the end
    add      = 5'd9,                                   // Add, new value back
    addAfter = 5'd10,                                  // Add, old value back
    subtract = 5'd11,                                  // Subtract, new value back
    subAfter = 5'd12,                                  // Subtract, old value back
    orOp     = 5'd13,
    xorOp    = 5'd14,
    andOp    = 5'd15,
    notOp    = 5'd16                                   // Bitwise invert
  } heapOp_e;

  typedef enum logic [2:0] {
    none         = 3'd0,
    notAllocated = 3'd1,                               // Handle above the counter
    freed        = 3'd2,                               // Handle released earlier
    outOfBounds  = 3'd3,                               // Index at or past the size
    full         = 3'd4,                               // Push onto a full array
    empty        = 3'd5,                               // Pop from an empty array
    outOfMemory  = 3'd6                                // No handle left to grant
  } heapError_e;

  // Words between the stages ------------------------
  typedef struct packed {
    heapOp_e                opcode;
    logic [addressBits-1:0] array;
    logic [indexBits-1:0]   index;
    logic [dataBits-1:0]    operand;
  } heapRequest_t;

  typedef struct packed {
    logic                   valid;                     // High for any non-idle opcode
    heapOp_e                opcode;
    logic [addressBits-1:0] array;                     // Granted handle on alloc
    logic [indexBits-1:0]   index;
    logic [dataBits-1:0]    operand;
    heapError_e             error;                     // Ownership verdict
  } checkedRequest_t;

  typedef struct packed {
    logic                   done;                      // One cycle per command
    logic [dataBits-1:0]    out;
    heapError_e             error;
  } heapResult_t;

endpackage

// ==== logic/elementAlu.sv ====
//------------------------------------------------
// Element ALU for read-modify-write opcodes
// New element value and the value handed back
//------------------------------------------------
`timescale 1ns/100ps

module elementAlu (
  input  heapPkg::heapOp_e             opcode,
  input  logic [heapPkg::dataBits-1:0] element,
  input  logic [heapPkg::dataBits-1:0] operand,
  output logic [heapPkg::dataBits-1:0] newValue,
  output logic [heapPkg::dataBits-1:0] returnValue
);
  import heapPkg::*;

  logic returnOld;                                   // After forms keep the old value

  assign returnOld = (opcode == addAfter) || (opcode == subAfter);

  always_comb begin
    case (opcode)
      add,
      addAfter: begin
        newValue = element + operand;                // Wraps at dataBits
      end
      subtract,
      subAfter: begin
        newValue = element - operand;
      end
      orOp:    newValue = element | operand;
      xorOp:   newValue = element ^ operand;
      andOp:   newValue = element & operand;
      notOp:   newValue = ~element;                  // Operand ignored
      default: newValue = element;                   // Element left as it is
    endcase
  end

  // Old element for the after forms, else the result
  assign returnValue = returnOld ? element : newValue;

endmodule

// ==== logic/heapChecker.sv ====
//------------------------------------------------
// Heap checker, first pipeline stage
// Grants and releases handles and flags access
// to arrays that are not owned
//------------------------------------------------
`timescale 1ns/100ps

module heapChecker (
  input  logic                     clock,
  input  logic                     reset,
  input  heapPkg::heapRequest_t    request,
  output heapPkg::checkedRequest_t checked
);
  import heapPkg::*;

  localparam logic [addressBits:0] maxCount = (addressBits + 1)'(arrayCount);

  // Allocation state --------------------------------
  logic [arrayCount-1:0]  owned;                       // One bit per live handle
  logic [addressBits:0]   allocCount;                  // Handles ever handed out
  logic [addressBits-1:0] freeStack [arrayCount];      // Released handles, LIFO
  logic [addressBits:0]   stackTop;                    // Entries on the stack

  logic [addressBits:0]   stackBelow;                  // Slot of the top entry
  logic [addressBits-1:0] handle;                      // Handle passed to the store
  heapError_e             checkError;
  logic                   checkOwner;                  // Opcode needs a live handle
  logic                   takeAlloc;                   // Alloc granted
  logic                   pushFree;                    // Free accepted

  assign stackBelow = stackTop - 1'b1;
  assign checkOwner = !(request.opcode inside {idle, clearAll, alloc});
  assign takeAlloc  = (request.opcode == alloc) && (checkError == none);
  assign pushFree   = (request.opcode == free) && (checkError == none);

  // Grant and ownership decision --------------------
  always_comb begin
    handle     = request.array;
    checkError = none;
    if (request.opcode == alloc) begin
      if (stackTop != '0) begin
        handle = freeStack[stackBelow[addressBits-1:0]];     // Reuse latest freed
      end else if (allocCount < maxCount) begin
        handle = allocCount[addressBits-1:0];                // Fresh handle
      end else begin
        checkError = outOfMemory;
      end
    end else if (checkOwner) begin
      if ({1'b0, request.array} >= allocCount) begin
        checkError = notAllocated;
      end else if (!owned[request.array]) begin
        checkError = freed;
      end
    end
  end

  // State update and stage register -----------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      owned      <= '0;
      allocCount <= '0;
      stackTop   <= '0;
      checked    <= '0;                                // Idle, no error
    end else begin
      checked.valid   <= request.opcode != idle;
      checked.opcode  <= request.opcode;
      checked.array   <= handle;
      checked.index   <= request.index;
      checked.operand <= request.operand;
      checked.error   <= checkError;

      if (request.opcode == clearAll) begin
        owned      <= '0;
        allocCount <= '0;
        stackTop   <= '0;                              // Drop all freed handles
      end else if (takeAlloc) begin
        owned[handle] <= 1'b1;
        if (stackTop != '0) begin
          stackTop <= stackBelow;                      // Pop the free stack
        end else begin
          allocCount <= allocCount + 1'b1;
        end
      end else if (pushFree) begin
        owned[request.array] <= 1'b0;
        stackTop             <= stackTop + 1'b1;
      end
    end
  end

  // Free stack storage
  always_ff @(posedge clock) begin
    if (pushFree) begin
      freeStack[stackTop[addressBits-1:0]] <= request.array;  // Never full here
    end
  end

endmodule

// ==== logic/arrayStore.sv ====
//------------------------------------------------
// Array store, second pipeline stage
// Holds elements and sizes, applies bounds rules
// and registers the result of each command
//------------------------------------------------
`timescale 1ns/100ps

module arrayStore (
  input  logic                     clock,
  input  logic                     reset,
  input  heapPkg::checkedRequest_t checked,
  output heapPkg::heapResult_t     result
);
  import heapPkg::*;

  localparam logic [indexBits:0] fullSize = (indexBits + 1)'(arrayLength);

  // Array contents ----------------------------------
  logic [dataBits-1:0] elements [arrayCount][arrayLength];
  logic [indexBits:0]  sizes    [arrayCount];        // 0 up to arrayLength

  logic [indexBits:0]  curSize;                      // Size of addressed array
  logic [indexBits:0]  lastSlot;                     // Index of the top element
  logic [dataBits-1:0] element;                      // Addressed element
  logic [dataBits-1:0] topValue;                     // Element popped off
  logic [dataBits-1:0] newValue;                     // From the ALU
  logic [dataBits-1:0] returnValue;                  // From the ALU
  logic [dataBits-1:0] outValue;
  logic                inBounds;
  logic                isAlu;                        // Read-modify-write opcode
  logic                commit;                       // Change state this edge
  heapError_e          storeError;

  assign curSize  = sizes[checked.array];
  assign lastSlot = curSize - 1'b1;
  assign element  = elements[checked.array][checked.index];
  assign topValue = elements[checked.array][lastSlot[indexBits-1:0]];
  assign inBounds = {1'b0, checked.index} < curSize;
  assign isAlu    = checked.opcode inside {add, addAfter, subtract, subAfter,
                                           orOp, xorOp, andOp, notOp};
  assign commit   = checked.valid && (storeError == none);

  elementAlu u_alu (
    .opcode      (checked.opcode),
    .element     (element),
    .operand     (checked.operand),
    .newValue    (newValue),
    .returnValue (returnValue)
  );

  // Bounds, full and empty checks -------------------
  always_comb begin
    storeError = checked.error;                      // Ownership errors win
    if (checked.error == none) begin
      if ((checked.opcode == read || isAlu) && !inBounds) begin
        storeError = outOfBounds;
      end else if (checked.opcode == push && curSize == fullSize) begin
        storeError = full;
      end else if (checked.opcode == pop && curSize == '0) begin
        storeError = empty;
      end
    end
  end

  // Value on out
  always_comb begin
    outValue = '0;
    if (storeError == none) begin
      case (checked.opcode)
        write:   outValue = checked.operand;
        read:    outValue = element;
        size:    outValue = dataBits'(curSize);
        alloc:   outValue = dataBits'(checked.array);
        pop:     outValue = topValue;
        default: outValue = isAlu ? returnValue : '0;  // Zero for push and free
      endcase
    end
  end

  // Storage update and result register --------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int a = 0; a < arrayCount; a++) begin
        sizes[a] <= '0;
        for (int i = 0; i < arrayLength; i++) begin
          elements[a][i] <= '0;
        end
      end
      result <= '0;                                  // Not done, no error
    end else begin
      result.done  <= checked.valid;
      result.out   <= outValue;
      result.error <= storeError;

      if (commit) begin
        case (checked.opcode)
          write: begin
            elements[checked.array][checked.index] <= checked.operand;
            if (!inBounds) begin
              sizes[checked.array] <= {1'b0, checked.index} + 1'b1;  // Grow to cover index
            end
          end
          alloc: begin
            sizes[checked.array] <= '0;              // New array starts empty
          end
          push: begin
            elements[checked.array][curSize[indexBits-1:0]] <= checked.operand;
            sizes[checked.array] <= curSize + 1'b1;
          end
          pop: begin
            sizes[checked.array] <= lastSlot;
          end
          default: begin
            if (isAlu) begin
              elements[checked.array][checked.index] <= newValue;
            end
          end
        endcase
      end
    end
  end

endmodule

// ==== logic/heapMemory.sv ====
//------------------------------------------------
// Heap of fixed-size arrays, top level
// Checker stage feeding the array store stage
//------------------------------------------------
`timescale 1ns/100ps

module heapMemory (
  input  logic                  clock,
  input  logic                  reset,
  input  heapPkg::heapRequest_t request,           // Idle opcode means no command
  output heapPkg::heapResult_t  result             // Two edges after the request
);
  import heapPkg::*;

  checkedRequest_t checked;                        // Stage one to stage two

  // Ownership and allocation ------------------------
  heapChecker u_checker (
    .clock   (clock),
    .reset   (reset),
    .request (request),
    .checked (checked)
  );

  // Element storage and execution -------------------
  arrayStore u_store (
    .clock   (clock),
    .reset   (reset),
    .checked (checked),
    .result  (result)
  );

endmodule

// ==== test/clockGen.sv ====
//------------------------------------------------
// Testbench clock and active low reset source
//------------------------------------------------
`timescale 1ns/100ps

module clockGen #(
  parameter int period      = 10,                  // Clock period in ns
  parameter int resetCycles = 8                    // Rising edges held in reset
) (
  output logic clock,
  output logic reset                               // Active low
);

  initial begin
    clock = 1'b0;
    forever #(period / 2) clock = ~clock;
  end

  initial begin
    reset = 1'b0;
    repeat (resetCycles) @(posedge clock);
    #1;                                            // Release off the edge
    reset = 1'b1;
  end

endmodule

// ==== test/heapModel.svh ====
//------------------------------------------------
// Reference model of the heap for the testbench
// One predict call per command, in issue order
//------------------------------------------------

int                     handleCount;               // Fresh handles handed out
logic                   liveHandle   [arrayCount];
logic [addressBits-1:0] freedHandles [$];          // Back is the top
int                     arraySize    [arrayCount];
logic [dataBits-1:0]    arrayData    [arrayCount][arrayLength];

function automatic void resetModel();
  handleCount = 0;
  freedHandles.delete();
  liveHandle = '{default: 1'b0};
  arraySize  = '{default: 0};
  arrayData  = '{default: '0};                     // Reset clears all elements
endfunction

function automatic heapResult_t predict(heapRequest_t req);
  heapResult_t            res;
  logic [addressBits-1:0] a;
  logic [indexBits-1:0]   i;
  logic [dataBits-1:0]    old;
  logic [dataBits-1:0]    updated;
  a   = req.array;
  i   = req.index;
  old = arrayData[a][i];
  res = '{done: 1'b1, out: '0, error: none};

  // Allocation state and ownership -----------------
  if (req.opcode == clearAll) begin
    handleCount = 0;
    freedHandles.delete();
    liveHandle = '{default: 1'b0};                 // Sizes and data stay
    return res;
  end
  if (req.opcode == alloc) begin
    if (freedHandles.size() > 0) begin
      a = freedHandles.pop_back();                 // Latest freed first
    end else if (handleCount < arrayCount) begin
      a = addressBits'(handleCount);
      handleCount++;
    end else begin
      res.error = outOfMemory;
      return res;
    end
    liveHandle[a] = 1'b1;
    arraySize[a]  = 0;
    res.out       = dataBits'(a);
    return res;
  end
  if (int'(a) >= handleCount) begin
    res.error = notAllocated;
    return res;
  end
  if (!liveHandle[a]) begin
    res.error = freed;
    return res;
  end

  // Array operations --------------------------------
  case (req.opcode)
    free: begin
      liveHandle[a] = 1'b0;
      freedHandles.push_back(a);
    end
    write: begin
      arrayData[a][i] = req.operand;
      if (int'(i) >= arraySize[a]) begin
        arraySize[a] = int'(i) + 1;                // Grows up to the index
      end
      res.out = req.operand;
    end
    read: begin
      if (int'(i) < arraySize[a]) begin
        res.out = old;
      end else begin
        res.error = outOfBounds;
      end
    end
    size: res.out = dataBits'(arraySize[a]);
    push: begin
      if (arraySize[a] == arrayLength) begin
        res.error = full;
      end else begin
        arrayData[a][indexBits'(arraySize[a])] = req.operand;
        arraySize[a]++;
      end
    end
    pop: begin
      if (arraySize[a] == 0) begin
        res.error = empty;
      end else begin
        arraySize[a]--;
        res.out = arrayData[a][indexBits'(arraySize[a])];  // Last pushed
      end
    end
    default: begin
      case (req.opcode)
        add, addAfter:      updated = old + req.operand;
        subtract, subAfter: updated = old - req.operand;
        orOp:               updated = old | req.operand;
        xorOp:              updated = old ^ req.operand;
        andOp:              updated = old & req.operand;
        default:            updated = ~old;        // Bitwise not
      endcase
      if (int'(i) >= arraySize[a]) begin
        res.error = outOfBounds;
      end else begin
        arrayData[a][i] = updated;
        res.out = (req.opcode inside {addAfter, subAfter}) ? old : updated;
      end
    end
  endcase
  return res;
endfunction

// ==== test/heapMemoryTb.sv ====
//------------------------------------------------
// Heap testbench with directed and random commands
// Each result is checked against a reference model
//------------------------------------------------
`timescale 1ns/100ps

module heapMemoryTb;
  import heapPkg::*;

  localparam int period           = 10;
  localparam int resetCycles      = 8;
  localparam int directedCommands = 80;            // Upper bound on the directed part
  localparam int randomCommands   = 2000;

  typedef struct packed {
    heapOp_e     opcode;
    int          due;                              // Edge count when done is due
    heapResult_t result;
  } expected_t;

  logic         clock;
  logic         reset;
  heapRequest_t request;
  heapResult_t  result;

  expected_t    pending [$];                       // Commands still in flight
  int           edgeCount = 0;
  int           mismatchCount;
  int           protocolCount;                     // Missing or extra done
  logic [31:0]  lfsrState;

  `include "heapModel.svh"

  clockGen #(.period(period), .resetCycles(resetCycles)) u_clock (
    .clock (clock),
    .reset (reset)
  );

  heapMemory u_dut (
    .clock   (clock),
    .reset   (reset),
    .request (request),
    .result  (result)
  );

  // Random source -----------------------------------
  function automatic logic nextBit();
    logic lsb;
    lsb       = lfsrState[0];
    lfsrState = lfsrState >> 1;
    if (lsb) begin
      lfsrState = lfsrState ^ 32'hA300_0000;       // Galois taps
    end
    return lsb;
  endfunction

  function automatic logic [31:0] randomBits(int count);
    logic [31:0] value;
    value = '0;
    for (int b = 0; b < count; b++) begin
      value = {value[30:0], nextBit()};
    end
    return value;
  endfunction

  // Drive one command and queue its expected result
  task automatic issue(heapOp_e opcode, int array, int index, int operand);
    expected_t entry;
    @(posedge clock);
    #1;
    request.opcode  = opcode;
    request.array   = addressBits'(array);
    request.index   = indexBits'(index);
    request.operand = dataBits'(operand);
    if (opcode != idle) begin
      entry.opcode = opcode;
      entry.due    = edgeCount + 2;                // Checker edge then store edge
      entry.result = predict(request);
      pending.push_back(entry);
    end
  endtask

  task automatic checkResult(expected_t entry);
    if (!result.done) begin
      protocolCount++;
      $display("no done at %0t for a %s command", $time, entry.opcode.name());
    end else if (result.out !== entry.result.out || result.error !== entry.result.error) begin
      mismatchCount++;
      $display("mismatch at %0t: %s gave out %h error %s, expected %h %s", $time,
               entry.opcode.name(), result.out, result.error.name(),
               entry.result.out, entry.result.error.name());
    end
  endtask

  // Result monitor ----------------------------------
  always @(posedge clock) begin
    edgeCount <= edgeCount + 1;
  end

  always @(negedge clock) begin                    // Outputs settled here
    if (pending.size() > 0 && pending[0].due == edgeCount) begin
      checkResult(pending.pop_front());
    end else if (result.done) begin
      protocolCount++;
      $display("done raised at %0t with no command waiting for it", $time);
    end
  end

  // Stimulus ----------------------------------------
  initial begin
    logic [31:0] pick;
    heapOp_e     opcode;
    int          array;
    int          index;
    int          operand;
    request       = '0;
    mismatchCount = 0;
    protocolCount = 0;
    lfsrState     = 32'h4f8b_468c;
    resetModel();
    wait (reset === 1'b1);

    if (result.done !== 1'b0 || result.out !== '0 || result.error !== none) begin
      mismatchCount++;
      $display("mismatch at %0t: after reset done %b out %h error %s", $time,
               result.done, result.out, result.error.name());
    end

    repeat (5) issue(alloc, 0, 0, 0);              // Handles 0 to 3 and then none left
    issue(free, 2, 0, 0);
    issue(free, 1, 0, 0);
    issue(alloc, 0, 0, 0);                         // LIFO reuse
    issue(alloc, 0, 0, 0);
    issue(free, 3, 0, 0);
    issue(read, 3, 0, 0);                          // Freed handle
    issue(clearAll, 0, 0, 0);
    for (int a = 0; a < arrayCount; a++) begin
      issue(size, a, 0, 0);                        // All unallocated again
    end
    issue(alloc, 0, 0, 0);
    issue(alloc, 0, 0, 0);
    issue(write, 3, 0, 0);

    issue(write, 0, 4, 16'h1234);                  // Size grows to 5
    issue(size, 0, 0, 0);
    issue(read, 0, 4, 0);
    issue(read, 0, 2, 0);
    issue(read, 0, 5, 0);                          // Past the size

    for (int n = 0; n <= arrayLength; n++) begin
      issue(push, 1, 0, 16'h0100 + n);             // Last one hits full
    end
    for (int n = 0; n <= arrayLength; n++) begin
      issue(pop, 1, 0, 0);                         // Last one hits empty
      issue(size, 1, 0, 0);
    end

    issue(add, 0, 4, 16'h0011);                    // Back to back on one element
    issue(addAfter, 0, 4, 16'h0100);
    issue(subtract, 0, 4, 16'h0003);
    issue(subAfter, 0, 4, 16'h0020);
    issue(orOp, 0, 4, 16'hf000);
    issue(xorOp, 0, 4, 16'h00ff);
    issue(andOp, 0, 4, 16'h7ff7);
    issue(notOp, 0, 4, 0);
    issue(read, 0, 4, 0);
    issue(add, 0, 6, 16'h0001);

    for (int n = 0; n < randomCommands; n++) begin
      pick = randomBits(5);
      if (pick >= 17) begin                        // Favour busy opcodes
        index  = int'((pick - 17) % 5);
        opcode = (index == 0) ? alloc : heapOp_e'(5'(3 + index));
      end else begin
        opcode = heapOp_e'(pick[4:0]);             // Idle gaps included
      end
      array   = int'(randomBits(addressBits));
      index   = int'(randomBits(indexBits));
      operand = int'(randomBits(dataBits));
      issue(opcode, array, index, operand);
    end
    issue(idle, 0, 0, 0);

    for (int w = 0; w < 8 && pending.size() > 0; w++) begin
      @(posedge clock);
    end
    $display("errors: %0d mismatches, %0d done errors", mismatchCount, protocolCount);
    if (mismatchCount + protocolCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog ----------------------------------------
  initial begin
    #((resetCycles + directedCommands + randomCommands + 20) * period);
    $display("timeout: the run did not finish in time");
    $display("** FAIL **");
    $finish;
  end

endmodule

// ==== heapMemory.f ====
+incdir+test
logic/heapPkg.sv
logic/elementAlu.sv
logic/heapChecker.sv
logic/arrayStore.sv
logic/heapMemory.sv
test/clockGen.sv
test/heapMemoryTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the heap testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module heapMemoryTb -f heapMemory.f \
  && ./obj_dir/VheapMemoryTb > sim.log 2>&1 \
  || echo "build or simulation failed"
cat sim.log 2>/dev/null
grep -qx '\*\* PASS \*\*' sim.log && echo "result: passed" || { echo "result: failed"; exit 1; }
